//--- files.f
hw/board_pkg.sv
hw/core_rst_seq.sv
hw/axi_mem_bridge.sv
hw/sim_sram.sv
hw/fan_pwm.sv
hw/board_top.sv
dv/tb_board_top.sv

//--- Bender.yml
package:
  name: board_top

sources:
  - files:
      - hw/board_pkg.sv
      - hw/core_rst_seq.sv
      - hw/axi_mem_bridge.sv
      - hw/sim_sram.sv
      - hw/fan_pwm.sv
      - hw/board_top.sv
  - target: test
    files:
      - dv/tb_board_top.sv

//--- dv/tb_board_top.sv
// Directed testbench for board_top. Checks reset sequencing, AXI write and
// read traffic against a reference memory model, and the fan PWM duty.
`timescale 1ns/1ps

module tb_board_top;

  localparam int MemWords     = 256;
  localparam int FanPrescale  = 4;
  localparam int SettleCycles = 64;                    // Default six-bit settle counter
  localparam int Timeout      = 20;

  logic                                  mig_ui_clk;
  logic                                  mig_ui_rst;
  logic                                  pll_locked;
  logic [board_pkg::FanSettingWidth-1:0] fan_setting;
  logic                                  core_rst_n;
  logic                                  fan_pwm;
  board_pkg::axi_req_t                   axi_req;
  board_pkg::axi_resp_t                  axi_resp;

  logic [board_pkg::DataWidth-1:0] model_mem [MemWords];   // Expected SRAM contents
  integer seed = 32'h8ca9_97d3;

  board_top #(
    .MemWords    ( MemWords    ),
    .FanPrescale ( FanPrescale )
  ) DUT (
    .mig_ui_clk    ( mig_ui_clk  ),
    .mig_ui_rst    ( mig_ui_rst  ),
    .pll_locked_i  ( pll_locked  ),
    .axi_req_i     ( axi_req     ),
    .axi_resp_o    ( axi_resp    ),
    .fan_setting_i ( fan_setting ),
    .core_rst_n_o  ( core_rst_n  ),
    .fan_pwm_o     ( fan_pwm     )
  );

  initial
  begin
    mig_ui_clk = 1'b0;
    forever #50 mig_ui_clk = ~mig_ui_clk;              // 100 ns period
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check_data(input logic [board_pkg::DataWidth-1:0] got,
                            input logic [board_pkg::DataWidth-1:0] exp, input string name);
    if (got !== exp)
    begin
      $display("ERROR: time %0t, %s: got %h, expected %h", $time, name, got, exp);
      stop_run("Data mismatch");
    end
  endtask

  task automatic check_id(input logic [board_pkg::IdWidth-1:0] got,
                          input logic [board_pkg::IdWidth-1:0] exp, input string name);
    if (got !== exp)
    begin
      $display("ERROR: time %0t, %s: got %h, expected %h", $time, name, got, exp);
      stop_run("Id mismatch");
    end
  endtask

  task automatic check_resp(input board_pkg::axi_resp_e got, input board_pkg::axi_resp_e exp,
                            input string name);
    if (got !== exp)
    begin
      $display("ERROR: time %0t, %s: got %s, expected %s", $time, name, got.name(), exp.name());
      stop_run("Response code mismatch");
    end
  endtask

  task automatic check_count(input int got, input int exp, input string name);
    if (got != exp)
    begin
      $display("ERROR: time %0t, %s: got %0d, expected %0d", $time, name, got, exp);
      stop_run("Count mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp)
    begin
      $display("ERROR: time %0t, %s: got %b, expected %b", $time, name, got, exp);
      stop_run("Bit mismatch");
    end
  endtask

  // Byte address to model index, offset dropped and upper bits aliased
  function automatic int word_index(input logic [board_pkg::AddrWidth-1:0] addr);
    return int'((addr >> 3) % MemWords);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                               input logic [63:0] new_word,
                                               input logic [7:0]  strb);
    logic [63:0] res;
    res = old_word;
    for (int b = 0; b < 8; b++)
    begin
      if (strb[b])
      begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // --------------------------------------------------------------------------
  // Bus driver tasks
  // --------------------------------------------------------------------------
  task automatic do_write(input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb, input logic [4:0] id, input int stall);
    int n;
    @(negedge mig_ui_clk);
    axi_req.aw_valid = 1'b1;
    axi_req.aw_id    = id;
    axi_req.aw_addr  = addr;
    axi_req.w_valid  = 1'b1;
    axi_req.w_data   = data;
    axi_req.w_strb   = strb;
    n = 0;
    @(posedge mig_ui_clk);                             // Handshake seen at the transfer edge
    while (!axi_resp.aw_ready)
    begin
      if (n == Timeout)
      begin
        stop_run("Timeout waiting for write acceptance");
      end
      @(posedge mig_ui_clk);
      n++;
    end
    check_bit(axi_resp.w_ready, 1'b1, "w_ready");
    @(negedge mig_ui_clk);
    check_bit(axi_resp.aw_ready, 1'b0, "aw_ready after acceptance");
    check_bit(axi_resp.w_ready, 1'b0, "w_ready after acceptance");
    axi_req.aw_valid = 1'b0;
    axi_req.w_valid  = 1'b0;
    check_bit(axi_resp.b_valid, 1'b1, "b_valid");
    check_id(axi_resp.b_id, id, "b_id");
    check_resp(axi_resp.b_resp, board_pkg::OKAY, "b_resp");
    repeat (stall)
    begin
      @(negedge mig_ui_clk);
      check_bit(axi_resp.b_valid, 1'b1, "b_valid under stall");
      check_id(axi_resp.b_id, id, "b_id under stall");
    end
    axi_req.b_ready = 1'b1;
    @(negedge mig_ui_clk);
    axi_req.b_ready = 1'b0;
    check_bit(axi_resp.b_valid, 1'b0, "b_valid after handshake");
    model_mem[word_index(addr)] = merge_bytes(model_mem[word_index(addr)], data, strb);
  endtask

  task automatic do_read(input logic [31:0] addr, input logic [4:0] id, input int stall,
                         output logic [63:0] data);
    int          n;
    logic [63:0] exp;
    exp = model_mem[word_index(addr)];
    @(negedge mig_ui_clk);
    axi_req.ar_valid = 1'b1;
    axi_req.ar_id    = id;
    axi_req.ar_addr  = addr;
    n = 0;
    @(posedge mig_ui_clk);
    while (!axi_resp.ar_ready)
    begin
      if (n == Timeout)
      begin
        stop_run("Timeout waiting for read address acceptance");
      end
      @(posedge mig_ui_clk);
      n++;
    end
    @(negedge mig_ui_clk);
    check_bit(axi_resp.ar_ready, 1'b0, "ar_ready after acceptance");
    axi_req.ar_valid = 1'b0;
    n = 0;
    while (!axi_resp.r_valid)
    begin
      if (n == Timeout)
      begin
        stop_run("Timeout waiting for read data");
      end
      @(negedge mig_ui_clk);
      n++;
    end
    data = axi_resp.r_data;
    check_id(axi_resp.r_id, id, "r_id");
    check_resp(axi_resp.r_resp, board_pkg::OKAY, "r_resp");
    check_bit(axi_resp.r_last, 1'b1, "r_last");
    check_data(axi_resp.r_data, exp, "r_data");
    repeat (stall)
    begin
      @(negedge mig_ui_clk);
      check_bit(axi_resp.r_valid, 1'b1, "r_valid under stall");
      check_id(axi_resp.r_id, id, "r_id under stall");
      check_data(axi_resp.r_data, exp, "r_data under stall");
    end
    axi_req.r_ready = 1'b1;
    @(negedge mig_ui_clk);
    axi_req.r_ready = 1'b0;
    check_bit(axi_resp.r_valid, 1'b0, "r_valid after handshake");
  endtask

  task automatic fill_memory();
    for (int i = 0; i < MemWords; i++)
    begin
      do_write(32'(i * 8), {i * 32'h9e37_79b9, ~i}, 8'hff, 5'(i), 0);
    end
  endtask

  // --------------------------------------------------------------------------
  // Reset and fan tests
  // --------------------------------------------------------------------------
  task automatic wait_reset_release();
    int n;
    axi_req.aw_valid = 1'b1;                           // Requests pending through reset
    axi_req.w_valid  = 1'b1;
    axi_req.ar_valid = 1'b1;
    for (n = 0; n < 200; n++)                          // PLL still unlocked
    begin
      @(negedge mig_ui_clk);
      check_bit(core_rst_n, 1'b0, "core_rst_n_o");
      check_bit(axi_resp.aw_ready | axi_resp.w_ready | axi_resp.ar_ready, 1'b0,
                "ready in reset");
      check_bit(axi_resp.b_valid | axi_resp.r_valid, 1'b0, "valid in reset");
      check_bit(fan_pwm, 1'b0, "fan_pwm_o in reset");
    end
    axi_req.aw_valid = 1'b0;
    axi_req.w_valid  = 1'b0;
    axi_req.ar_valid = 1'b0;
    pll_locked = 1'b1;
    n = 0;
    while (!core_rst_n)
    begin
      if (n == 3)
      begin
        stop_run("Core reset not released within 3 cycles of PLL lock");
      end
      @(negedge mig_ui_clk);
      n++;
    end

    // Release again with the PLL already locked, only the settle count holds the core
    mig_ui_rst = 1'b1;
    @(negedge mig_ui_clk);
    check_bit(core_rst_n, 1'b0, "core_rst_n_o in reset");
    mig_ui_rst = 1'b0;
    n = 0;
    while (!core_rst_n)
    begin
      if (n == SettleCycles + 4)
      begin
        stop_run("Core reset not released after the settle count");
      end
      @(negedge mig_ui_clk);
      n++;
    end
    check_count(n, SettleCycles, "cycles from reset release to core release");
  endtask

  task automatic measure_fan(input logic [3:0] setting);
    int high;
    @(negedge mig_ui_clk);
    fan_setting = setting;
    repeat (2) @(negedge mig_ui_clk);                  // Let the new setting reach the flop
    high = 0;
    repeat (16 * FanPrescale)
    begin
      @(negedge mig_ui_clk);
      if (fan_pwm)
      begin
        high++;
      end
    end
    check_count(high, int'(setting) * FanPrescale, "fan high cycles");
  endtask

  initial
  begin
    logic [63:0] base_word;
    logic [63:0] alias_word;
    logic [31:0] addr;
    mig_ui_rst  = 1'b1;
    pll_locked  = 1'b0;
    fan_setting = '0;
    axi_req     = '0;
    repeat (5) @(negedge mig_ui_clk);
    mig_ui_rst = 1'b0;
    wait_reset_release();
    fill_memory();

    // Full word with response back-pressure
    do_write(32'h0000_0040, 64'h0123_4567_89ab_cdef, 8'hff, 5'h13, 5);
    do_read(32'h0000_0040, 5'h0a, 5, base_word);
    check_data(base_word, 64'h0123_4567_89ab_cdef, "read back word");

    // Partial strobe over a known word
    do_write(32'h0000_0088, 64'h1111_1111_1111_1111, 8'hff, 5'h01, 0);
    do_write(32'h0000_0088, 64'hffee_ddcc_bbaa_9988, 8'h5a, 5'h02, 0);
    do_read(32'h0000_0088, 5'h03, 0, base_word);
    check_data(base_word, 64'h11ee_11cc_bb11_9911, "merged word");

    for (int k = 0; k < 50; k++)
    begin
      addr = $random(seed);
      if ($random(seed) & 1)
      begin
        do_write(addr, {$random(seed), $random(seed)}, 8'($random(seed)), 5'($random(seed)), 0);
      end
      else
      begin
        do_read(addr, 5'($random(seed)), 0, base_word);
      end
    end

    addr = 32'h0000_0128;
    do_read(addr, 5'h04, 0, base_word);
    do_read(addr + MemWords * 8, 5'h05, 0, alias_word);    // Wraps onto same word
    check_data(alias_word, model_mem[word_index(addr)], "aliased read");

    measure_fan(4'd0);
    measure_fan(4'd5);
    measure_fan(4'd15);

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- hw/board_top.sv
// Simulation top level of the board. Sequences the core reset, puts an AXI
// slave and SRAM on the external bus, and drives the fan PWM.
`timescale 1ns/1ps

module board_top #(
  parameter int unsigned MemWords      = 1024,
  parameter int unsigned RstCountWidth = 6,
  parameter int unsigned FanPrescale   = 1024
) (
  input  logic                                  mig_ui_clk,
  input  logic                                  mig_ui_rst,
  input  logic                                  pll_locked_i,
  input  board_pkg::axi_req_t                   axi_req_i,
  output board_pkg::axi_resp_t                  axi_resp_o,
  input  logic [board_pkg::FanSettingWidth-1:0] fan_setting_i,
  output logic                                  core_rst_n_o,
  output logic                                  fan_pwm_o
);

  logic                            mem_req;
  logic                            mem_we;
  logic [$clog2(MemWords)-1:0]     mem_addr;
  logic [board_pkg::DataWidth-1:0] mem_wdata;
  logic [board_pkg::StrbWidth-1:0] mem_be;
  logic [board_pkg::DataWidth-1:0] mem_rdata;

  // --------------------------------------------------------------------------
  // Reset
  // --------------------------------------------------------------------------
  core_rst_seq #(
    .RstCountWidth ( RstCountWidth )
  ) i_core_rst_seq (
    .mig_ui_clk   ( mig_ui_clk   ),
    .mig_ui_rst   ( mig_ui_rst   ),
    .pll_locked_i ( pll_locked_i ),
    .core_rst_n_o ( core_rst_n_o )               // Reset for everything below
  );

  // --------------------------------------------------------------------------
  // Memory path
  // --------------------------------------------------------------------------
  axi_mem_bridge #(
    .MemWords ( MemWords )
  ) i_axi_mem_bridge (
    .mig_ui_clk   ( mig_ui_clk   ),
    .core_rst_n_i ( core_rst_n_o ),
    .axi_req_i    ( axi_req_i    ),
    .axi_resp_o   ( axi_resp_o   ),
    .mem_req_o    ( mem_req      ),
    .mem_we_o     ( mem_we       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_be_o     ( mem_be       ),
    .mem_rdata_i  ( mem_rdata    )
  );

  sim_sram #(
    .MemWords ( MemWords )
  ) i_sim_sram (
    .mig_ui_clk   ( mig_ui_clk   ),
    .core_rst_n_i ( core_rst_n_o ),
    .req_i        ( mem_req      ),
    .we_i         ( mem_we       ),
    .addr_i       ( mem_addr     ),
    .wdata_i      ( mem_wdata    ),
    .be_i         ( mem_be       ),
    .rdata_o      ( mem_rdata    )
  );

  // Board fan
  fan_pwm #(
    .FanPrescale ( FanPrescale )
  ) i_fan_pwm (
    .mig_ui_clk   ( mig_ui_clk    ),
    .core_rst_n_i ( core_rst_n_o  ),
    .setting_i    ( fan_setting_i ),
    .fan_pwm_o    ( fan_pwm_o     )
  );

endmodule

//--- hw/fan_pwm.sv
// Board fan PWM. A prescaler advances a 16-step counter and the output is
// high for the first setting_i steps of every period.
`timescale 1ns/1ps

module fan_pwm #(
  parameter int unsigned FanPrescale = 1024
) (
  input  logic                                  mig_ui_clk,
  input  logic                                  core_rst_n_i,
  input  logic [board_pkg::FanSettingWidth-1:0] setting_i,
  output logic                                  fan_pwm_o
);

  localparam int unsigned PreWidth = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;

  logic [PreWidth-1:0]                  prescale_q;
  logic [board_pkg::FanSettingWidth-1:0] step_q;
  logic                                 step_tick;

  assign step_tick = (prescale_q == PreWidth'(FanPrescale - 1));

  always_ff @(posedge mig_ui_clk or negedge core_rst_n_i)
  begin
    if (!core_rst_n_i)
    begin
      prescale_q <= '0;
      step_q     <= '0;
      fan_pwm_o  <= 1'b0;
    end
    else
    begin
      if (step_tick)
      begin
        prescale_q <= '0;
        step_q     <= step_q + 1'b1;               // Wraps after 16 steps
      end
      else
      begin
        prescale_q <= prescale_q + 1'b1;
      end
      fan_pwm_o <= (step_q < setting_i);           // Setting 0 keeps fan off
    end
  end

endmodule

//--- hw/sim_sram.sv
// Word-organized simulation memory with byte enables. A read request
// returns its word on rdata_o one clock later.
`timescale 1ns/1ps

module sim_sram #(
  parameter int unsigned MemWords = 1024
) (
  input  logic                              mig_ui_clk,
  input  logic                              core_rst_n_i,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [$clog2(MemWords)-1:0]       addr_i,
  input  logic [board_pkg::DataWidth-1:0]   wdata_i,
  input  logic [board_pkg::StrbWidth-1:0]   be_i,
  output logic [board_pkg::DataWidth-1:0]   rdata_o
);

  logic [board_pkg::DataWidth-1:0] mem_q [MemWords];

  // Bytewise write under the strobes
  always_ff @(posedge mig_ui_clk)
  begin
    for (int i = 0; i < board_pkg::StrbWidth; i++)
    begin
      if (req_i && we_i && be_i[i])
      begin
        mem_q[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge mig_ui_clk or negedge core_rst_n_i)
  begin
    if (!core_rst_n_i)
    begin
      rdata_o <= '0;
    end
    else if (req_i && !we_i)
    begin
      rdata_o <= mem_q[addr_i];                    // One cycle read latency
    end
  end

  a_addr_known: assert property (
    @(posedge mig_ui_clk) disable iff (!core_rst_n_i)
    req_i |-> !$isunknown(addr_i)
  );

endmodule

//--- hw/axi_mem_bridge.sv
// Single-beat AXI slave in front of a word-wide SRAM. Accepts one write or
// read at a time and turns it into one SRAM word access.
`timescale 1ns/1ps

module axi_mem_bridge #(
  parameter int unsigned MemWords = 1024
) (
  input  logic                              mig_ui_clk,
  input  logic                              core_rst_n_i,
  input  board_pkg::axi_req_t               axi_req_i,
  output board_pkg::axi_resp_t              axi_resp_o,
  output logic                              mem_req_o,
  output logic                              mem_we_o,
  output logic [$clog2(MemWords)-1:0]       mem_addr_o,
  output logic [board_pkg::DataWidth-1:0]   mem_wdata_o,
  output logic [board_pkg::StrbWidth-1:0]   mem_be_o,
  input  logic [board_pkg::DataWidth-1:0]   mem_rdata_i
);

  localparam int unsigned MemAddrWidth = $clog2(MemWords);
  localparam int unsigned OffsetWidth  = $clog2(board_pkg::StrbWidth);

  typedef enum logic [1:0] {
    IDLE,
    WR_RESP,
    RD_WAIT,
    RD_RESP
  } state_e;

  state_e                          state_q, state_d;
  logic                            wr_accept;
  logic                            rd_accept;
  logic [board_pkg::IdWidth-1:0]   id_q;
  logic [board_pkg::DataWidth-1:0] rdata_q;

  // --------------------------------------------------------------------------
  // Acceptance, write wins over read in the same idle cycle
  // --------------------------------------------------------------------------
  // Nothing is taken while the core is held in reset
  assign wr_accept = core_rst_n_i && (state_q == IDLE) &&
                     axi_req_i.aw_valid && axi_req_i.w_valid;
  assign rd_accept = core_rst_n_i && (state_q == IDLE) && !wr_accept && axi_req_i.ar_valid;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (wr_accept)
        begin
          state_d = WR_RESP;
        end
        else if (rd_accept)
        begin
          state_d = RD_WAIT;
        end
      end
      WR_RESP:
      begin
        if (axi_req_i.b_ready)
        begin
          state_d = IDLE;
        end
      end
      RD_WAIT: state_d = RD_RESP;                  // SRAM word arrives now
      RD_RESP:
      begin
        if (axi_req_i.r_ready)
        begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge mig_ui_clk or negedge core_rst_n_i)
  begin
    if (!core_rst_n_i)
    begin
      state_q <= IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Response payload, held while the master stalls
  always_ff @(posedge mig_ui_clk)
  begin
    if (wr_accept)
    begin
      id_q <= axi_req_i.aw_id;
    end
    else if (rd_accept)
    begin
      id_q <= axi_req_i.ar_id;
    end
    if (state_q == RD_WAIT)
    begin
      rdata_q <= mem_rdata_i;
    end
  end

  // --------------------------------------------------------------------------
  // SRAM side, byte address to word address
  // --------------------------------------------------------------------------
  assign mem_req_o   = wr_accept | rd_accept;
  assign mem_we_o    = wr_accept;
  assign mem_addr_o  = wr_accept ? axi_req_i.aw_addr[OffsetWidth +: MemAddrWidth]
                                 : axi_req_i.ar_addr[OffsetWidth +: MemAddrWidth];
  assign mem_wdata_o = axi_req_i.w_data;
  assign mem_be_o    = axi_req_i.w_strb;

  always_comb
  begin
    axi_resp_o          = '0;
    axi_resp_o.aw_ready = wr_accept;                // AW and W taken together
    axi_resp_o.w_ready  = wr_accept;
    axi_resp_o.b_valid  = (state_q == WR_RESP);
    axi_resp_o.b_id     = id_q;
    axi_resp_o.b_resp   = board_pkg::OKAY;
    axi_resp_o.ar_ready = rd_accept;
    axi_resp_o.r_valid  = (state_q == RD_RESP);
    axi_resp_o.r_id     = id_q;
    axi_resp_o.r_data   = rdata_q;
    axi_resp_o.r_resp   = board_pkg::OKAY;
    axi_resp_o.r_last   = 1'b1;                     // Single beat
  end

  a_one_resp: assert property (
    @(posedge mig_ui_clk) disable iff (!core_rst_n_i)
    !(axi_resp_o.b_valid && axi_resp_o.r_valid)
  );

  // Master keeps a write pending until both channels are taken
  a_wr_held: assert property (
    @(posedge mig_ui_clk) disable iff (!core_rst_n_i)
    axi_req_i.aw_valid && axi_req_i.w_valid && !axi_resp_o.aw_ready
    |=> axi_req_i.aw_valid && axi_req_i.w_valid
  );

endmodule

//--- hw/core_rst_seq.sv
// Core reset sequencer. Holds the core in reset after the clock generator
// reset until a settle counter saturates and the PLL reports lock.
`timescale 1ns/1ps

module core_rst_seq #(
  parameter int unsigned RstCountWidth = 6
) (
  input  logic mig_ui_clk,
  input  logic mig_ui_rst,
  input  logic pll_locked_i,
  output logic core_rst_n_o
);

  logic [RstCountWidth-1:0] settle_cnt_q;
  logic                     settled;

  assign settled = &settle_cnt_q;                  // Counter saturated

  always_ff @(posedge mig_ui_clk or posedge mig_ui_rst)
  begin
    if (mig_ui_rst)
    begin
      settle_cnt_q <= '0;
      core_rst_n_o <= 1'b0;
    end
    else
    begin
      if (!settled)
      begin
        settle_cnt_q <= settle_cnt_q + 1'b1;
      end
      if (settled && pll_locked_i)
      begin
        core_rst_n_o <= 1'b1;                      // Sticky until next reset
      end
    end
  end

  // Release is final, losing lock later must not pull the core back into reset
  a_rst_sticky: assert property (
    @(posedge mig_ui_clk) disable iff (mig_ui_rst)
    core_rst_n_o |=> core_rst_n_o
  );

endmodule

//--- hw/board_pkg.sv
// Shared bus widths and AXI request/response types for the board top level.
// RTL and testbench both refer to these by scoped name.
package board_pkg;

  // --------------------------------------------------------------------------
  // Bus geometry
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth       = 32;           // Byte address
  localparam int unsigned DataWidth       = 64;           // One beat, one SRAM word
  localparam int unsigned StrbWidth       = DataWidth / 8;
  localparam int unsigned IdWidth         = 4 + 1;        // Master id plus crossbar bit
  localparam int unsigned FanSettingWidth = 4;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // Master to slave, single-beat transfers only
  typedef struct packed {
    logic                 aw_valid;
    logic [IdWidth-1:0]   aw_id;
    logic [AddrWidth-1:0] aw_addr;
    logic                 w_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 b_ready;
    logic                 ar_valid;
    logic [IdWidth-1:0]   ar_id;
    logic [AddrWidth-1:0] ar_addr;
    logic                 r_ready;
  } axi_req_t;

  // Slave to master
  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic                 b_valid;
    logic [IdWidth-1:0]   b_id;
    axi_resp_e            b_resp;
    logic                 ar_ready;
    logic                 r_valid;
    logic [IdWidth-1:0]   r_id;
    logic [DataWidth-1:0] r_data;
    axi_resp_e            r_resp;
    logic                 r_last;
  } axi_resp_t;

endpackage
